// ==== vlog.f ====
ppi_bus_pkg.sv
ppi_regs_pkg.sv
ppi_fabric.sv
hclkgen_regs.sv
gpio_regs.sv
perips_top.sv
tb_perips.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the peripheral testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --top-module tb_perips -f vlog.f -o tb_perips \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_perips > sim.log 2>&1 ; cat sim.log

grep -q '^PASS: all tests$' sim.log && echo "Simulation result: pass" \
  || { echo "Simulation result: fail"; exit 1; }

// ==== tb_perips.sv ====
module tb_perips
  import ppi_bus_pkg::*;
  import ppi_regs_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int RST_CYCLES = 10;
  // Gap before each command, long enough for a pad change to reach GPIO_VALUE
  localparam int IDLE_CYCLES = 4;
  localparam logic RD = 1'b1;
  localparam logic WR = 1'b0;

  // Output group compared once an access is done
  typedef enum logic [3:0] {
    CHK_NONE, CHK_PLLCFG, CHK_PLLDIV, CHK_HFXOSC,
    CHK_OE, CHK_OVAL, CHK_IE, CHK_PUE, CHK_DS, CHK_IRQ
  } chk_e;

  typedef struct packed {
    logic  rd;
    addr_t addr;
    data_t wdata;
    data_t pad;
    data_t exp_rdata;
    logic  exp_err;
    chk_e  chk;
    data_t exp_out;
  } entry_t;

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic                   i_cmd_valid;
  logic                   o_cmd_ready;
  addr_t                  i_cmd_addr;
  logic                   i_cmd_read;
  data_t                  i_cmd_wdata;
  logic                   o_rsp_valid;
  logic                   i_rsp_ready;
  logic                   o_rsp_err;
  data_t                  o_rsp_rdata;
  logic [GPIO_W-1:0]      i_gpio_ival;
  logic [GPIO_W-1:0]      o_gpio_oval;
  logic [GPIO_W-1:0]      o_gpio_oe;
  logic [GPIO_W-1:0]      o_gpio_ie;
  logic [GPIO_W-1:0]      o_gpio_pue;
  logic [GPIO_W-1:0]      o_gpio_ds;
  logic [GPIO_W-1:0]      o_gpio_irq;
  logic                   o_pllbypass;
  logic                   o_pll_reset;
  logic                   o_pll_asleep;
  logic [PLL_OD_W-1:0]    o_pll_od;
  logic [PLL_M_W-1:0]     o_pll_m;
  logic [PLL_N_W-1:0]     o_pll_n;
  logic                   o_plloutdivby1;
  logic [PLLOUTDIV_W-1:0] o_plloutdiv;
  logic                   o_hfxoscen;

  entry_t      tbl[$];
  logic [31:0] lfsr_q;
  int          cycle_cnt = 0;
  int          cycle_limit;

  perips_top uut (.*);

  always #4 clk = ~clk;

  // Watchdog
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d clock cycles", cycle_limit);
      stop_with_failure();
    end
  end

  task automatic stop_with_failure();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_eq(input string name, input data_t exp, input data_t act);
    assert (act === exp) else begin
      $display("ERROR: time %0d ns, %s expected 0x%08h, actual 0x%08h", $time, name, exp, act);
      stop_with_failure();
    end
  endtask

  // Packed PLLCFG layout: N[4:0], M[12:5], OD[14:13], bypass 15, reset 16, asleep 17
  function automatic data_t pllcfg_word(input logic [4:0] n, input logic [7:0] m,
                                        input logic [1:0] od, input logic bypass,
                                        input logic pll_rst, input logic asleep);
    return {14'd0, asleep, pll_rst, bypass, od, m, n};
  endfunction

  // div[5:0], divby1 at bit 8
  function automatic data_t plldiv_word(input logic [5:0] div, input logic by1);
    return {23'd0, by1, 2'b00, div};
  endfunction

  function automatic addr_t hclk_addr(input logic [11:0] ofs);
    return HCLKGEN_BASE + addr_t'(ofs);
  endfunction

  function automatic addr_t gpio_addr(input logic [11:0] ofs);
    return GPIO_BASE + addr_t'(ofs);
  endfunction

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Two bits, one LFSR step each
  task automatic draw_stall(output int n);
    n = 0;
    repeat (2) begin
      lfsr_q = lfsr_next(lfsr_q);
      n = (n << 1) | int'(lfsr_q[0]);
    end
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic add_entry(input logic rd, input addr_t addr, input data_t wdata,
                           input data_t pad, input data_t exp_rdata, input logic exp_err,
                           input chk_e chk, input data_t exp_out);
    entry_t e;
    e.rd        = rd;
    e.addr      = addr;
    e.wdata     = wdata;
    e.pad       = pad;
    e.exp_rdata = exp_rdata;
    e.exp_err   = exp_err;
    e.chk       = chk;
    e.exp_out   = exp_out;
    tbl.push_back(e);
  endtask

  task automatic build_table();
    data_t cfg_rst;
    data_t div_rst;
    data_t cfg_new;
    data_t div_new;
    cfg_rst = pllcfg_word(5'd1, 8'h32, 2'd0, 1'b1, 1'b0, 1'b0);
    div_rst = plldiv_word(6'd0, 1'b1);
    cfg_new = pllcfg_word(5'h0A, 8'hA5, 2'd2, 1'b0, 1'b1, 1'b1);
    div_new = plldiv_word(6'h15, 1'b0);
    // Clock generator after reset
    add_entry(RD, hclk_addr(HCLK_PLLCFG_OFS), '0, '0, cfg_rst, 1'b0, CHK_PLLCFG, cfg_rst);
    add_entry(RD, hclk_addr(HCLK_PLLDIV_OFS), '0, '0, div_rst, 1'b0, CHK_PLLDIV, div_rst);
    add_entry(RD, hclk_addr(HCLK_HFXOSC_OFS), '0, '0, 32'd1, 1'b0, CHK_HFXOSC, 32'd1);
    // Writes carry stray bits outside the fields
    add_entry(WR, hclk_addr(HCLK_PLLCFG_OFS), 32'hFFFC_0000 | cfg_new, '0,
              '0, 1'b0, CHK_PLLCFG, cfg_new);
    add_entry(RD, hclk_addr(HCLK_PLLCFG_OFS), '0, '0, cfg_new, 1'b0, CHK_PLLCFG, cfg_new);
    add_entry(WR, hclk_addr(HCLK_PLLDIV_OFS), 32'hFFFF_FEC0 | div_new, '0,
              '0, 1'b0, CHK_PLLDIV, div_new);
    add_entry(RD, hclk_addr(HCLK_PLLDIV_OFS), '0, '0, div_new, 1'b0, CHK_PLLDIV, div_new);
    add_entry(WR, hclk_addr(HCLK_HFXOSC_OFS), 32'hFFFF_FFFE, '0, '0, 1'b0, CHK_HFXOSC, '0);
    add_entry(RD, hclk_addr(HCLK_HFXOSC_OFS), '0, '0, '0, 1'b0, CHK_HFXOSC, '0);
    // Unmapped pages, registers untouched
    add_entry(RD, 32'h1000_0000, '0, '0, '0, 1'b1, CHK_NONE, '0);
    add_entry(WR, 32'h1001_0000, 32'hDEAD_BEEF, '0, '0, 1'b1, CHK_NONE, '0);
    add_entry(WR, 32'h1100_0000, 32'hFFFF_FFFF, '0, '0, 1'b1, CHK_PLLCFG, cfg_new);
    add_entry(RD, hclk_addr(HCLK_PLLCFG_OFS), '0, '0, cfg_new, 1'b0, CHK_PLLCFG, cfg_new);
    add_entry(RD, hclk_addr(HCLK_PLLDIV_OFS), '0, '0, div_new, 1'b0, CHK_PLLDIV, div_new);
    // GPIO pad controls
    add_entry(WR, gpio_addr(GPIO_OUTPUT_EN_OFS), 32'h0000_FFFF, '0, '0, 1'b0,
              CHK_OE, 32'h0000_FFFF);
    add_entry(WR, gpio_addr(GPIO_PORT_OFS), 32'hA5A5_5A5A, '0, '0, 1'b0, CHK_OVAL, 32'hA5A5_5A5A);
    add_entry(WR, gpio_addr(GPIO_INPUT_EN_OFS), 32'hFFFF_0000, '0, '0, 1'b0,
              CHK_IE, 32'hFFFF_0000);
    add_entry(WR, gpio_addr(GPIO_PUE_OFS), 32'h0F0F_0F0F, '0, '0, 1'b0, CHK_PUE, 32'h0F0F_0F0F);
    add_entry(WR, gpio_addr(GPIO_DS_OFS), 32'h3C3C_C3C3, '0, '0, 1'b0, CHK_DS, 32'h3C3C_C3C3);
    add_entry(RD, gpio_addr(GPIO_OUTPUT_EN_OFS), '0, '0, 32'h0000_FFFF, 1'b0, CHK_NONE, '0);
    add_entry(RD, gpio_addr(GPIO_PORT_OFS), '0, '0, 32'hA5A5_5A5A, 1'b0, CHK_NONE, '0);
    add_entry(RD, gpio_addr(GPIO_INPUT_EN_OFS), '0, '0, 32'hFFFF_0000, 1'b0, CHK_NONE, '0);
    add_entry(RD, gpio_addr(GPIO_PUE_OFS), '0, '0, 32'h0F0F_0F0F, 1'b0, CHK_NONE, '0);
    add_entry(RD, gpio_addr(GPIO_DS_OFS), '0, '0, 32'h3C3C_C3C3, 1'b0, CHK_NONE, '0);
    // Input path, rise pending and interrupts on pins 16 and 17
    add_entry(WR, gpio_addr(GPIO_RISE_IE_OFS), 32'h0003_0000, '0, '0, 1'b0, CHK_IRQ, '0);
    add_entry(WR, gpio_addr(GPIO_RISE_IP_OFS), 32'hFFFF_FFFF, '0, '0, 1'b0, CHK_IRQ, '0);
    // Low half masked off by INPUT_EN
    add_entry(RD, gpio_addr(GPIO_VALUE_OFS), '0, 32'h1234_5678, 32'h1234_0000, 1'b0,
              CHK_IRQ, '0);
    add_entry(RD, gpio_addr(GPIO_RISE_IP_OFS), '0, 32'h1237_5678, 32'h1237_0000, 1'b0,
              CHK_IRQ, 32'h0003_0000);
    add_entry(WR, gpio_addr(GPIO_RISE_IP_OFS), 32'h0001_0000, 32'h1237_5678, '0, 1'b0,
              CHK_IRQ, 32'h0002_0000);
    add_entry(RD, gpio_addr(GPIO_RISE_IP_OFS), '0, 32'h1237_5678, 32'h1236_0000, 1'b0,
              CHK_IRQ, 32'h0002_0000);
    add_entry(RD, gpio_addr(GPIO_VALUE_OFS), '0, 32'h1237_5678, 32'h1237_0000, 1'b0,
              CHK_NONE, '0);
  endtask

  task automatic check_outputs(input chk_e sel, input data_t exp);
    case (sel)
      CHK_PLLCFG: check_eq("pll cfg outputs", exp, pllcfg_word(o_pll_n, o_pll_m, o_pll_od,
                           o_pllbypass, o_pll_reset, o_pll_asleep));
      CHK_PLLDIV: check_eq("pll div outputs", exp, plldiv_word(o_plloutdiv, o_plloutdivby1));
      CHK_HFXOSC: check_eq("o_hfxoscen", exp, 32'(o_hfxoscen));
      CHK_OE:     check_eq("o_gpio_oe", exp, data_t'(o_gpio_oe));
      CHK_OVAL:   check_eq("o_gpio_oval", exp, data_t'(o_gpio_oval));
      CHK_IE:     check_eq("o_gpio_ie", exp, data_t'(o_gpio_ie));
      CHK_PUE:    check_eq("o_gpio_pue", exp, data_t'(o_gpio_pue));
      CHK_DS:     check_eq("o_gpio_ds", exp, data_t'(o_gpio_ds));
      CHK_IRQ:    check_eq("o_gpio_irq", exp, data_t'(o_gpio_irq));
      default: ;
    endcase
  endtask

  task automatic run_entry(input entry_t e);
    int    stall;
    int    lat;
    data_t rdata;
    logic  err;
    i_gpio_ival = e.pad;
    repeat (IDLE_CYCLES) step();
    i_cmd_valid = 1'b1;
    i_cmd_addr  = e.addr;
    i_cmd_read  = e.rd;
    i_cmd_wdata = e.wdata;
    // Command goes on the edge after ready is seen
    while (!o_cmd_ready) begin
      step();
    end
    step();
    i_cmd_valid = 1'b0;
    check_eq("o_cmd_ready", 32'd0, 32'(o_cmd_ready));
    lat = 1;
    while (!o_rsp_valid) begin
      step();
      lat++;
    end
    check_eq("response latency", 32'd1, 32'(lat));
    rdata = o_rsp_rdata;
    err   = o_rsp_err;
    // Hold off the response, everything stays frozen
    draw_stall(stall);
    repeat (stall) begin
      step();
      check_eq("o_rsp_valid", 32'd1, 32'(o_rsp_valid));
      check_eq("o_rsp_rdata", rdata, o_rsp_rdata);
      check_eq("o_rsp_err", 32'(err), 32'(o_rsp_err));
      check_eq("o_cmd_ready", 32'd0, 32'(o_cmd_ready));
    end
    i_rsp_ready = 1'b1;
    step();
    i_rsp_ready = 1'b0;
    check_eq("o_rsp_err", 32'(e.exp_err), 32'(err));
    if (e.rd || e.exp_err) begin
      check_eq("o_rsp_rdata", e.exp_rdata, rdata);
    end
    // Port opens again once the response is taken
    check_eq("o_cmd_ready", 32'd1, 32'(o_cmd_ready));
    check_outputs(e.chk, e.exp_out);
  endtask

  initial begin
    rst_n       = 1'b0;
    i_cmd_valid = 1'b0;
    i_cmd_addr  = '0;
    i_cmd_read  = 1'b0;
    i_cmd_wdata = '0;
    i_rsp_ready = 1'b0;
    i_gpio_ival = '0;
    lfsr_q      = 32'h6b38;
    build_table();
    cycle_limit = 40 * tbl.size() + RST_CYCLES;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // Idle state straight after reset
    check_eq("o_cmd_ready", 32'd1, 32'(o_cmd_ready));
    check_eq("o_rsp_valid", 32'd0, 32'(o_rsp_valid));
    check_eq("o_rsp_err", 32'd0, 32'(o_rsp_err));
    check_eq("o_gpio_oe", 32'd0, data_t'(o_gpio_oe));
    check_eq("o_gpio_irq", 32'd0, data_t'(o_gpio_irq));
    foreach (tbl[i]) begin
      run_entry(tbl[i]);
    end
    $display("PASS: all tests");
    $finish;
  end

endmodule

// ==== perips_top.sv ====
module perips_top
  import ppi_bus_pkg::*;
  import ppi_regs_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  // Peripheral bus port
  input  logic                   i_cmd_valid,
  output logic                   o_cmd_ready,
  input  addr_t                  i_cmd_addr,
  input  logic                   i_cmd_read,
  input  data_t                  i_cmd_wdata,
  output logic                   o_rsp_valid,
  input  logic                   i_rsp_ready,
  output logic                   o_rsp_err,
  output data_t                  o_rsp_rdata,
  // GPIO pads and interrupts
  input  logic [GPIO_W-1:0]      i_gpio_ival,
  output logic [GPIO_W-1:0]      o_gpio_oval,
  output logic [GPIO_W-1:0]      o_gpio_oe,
  output logic [GPIO_W-1:0]      o_gpio_ie,
  output logic [GPIO_W-1:0]      o_gpio_pue,
  output logic [GPIO_W-1:0]      o_gpio_ds,
  output logic [GPIO_W-1:0]      o_gpio_irq,
  // Clock generator controls
  output logic                   o_pllbypass,
  output logic                   o_pll_reset,
  output logic                   o_pll_asleep,
  output logic [PLL_OD_W-1:0]    o_pll_od,
  output logic [PLL_M_W-1:0]     o_pll_m,
  output logic [PLL_N_W-1:0]     o_pll_n,
  output logic                   o_plloutdivby1,
  output logic [PLLOUTDIV_W-1:0] o_plloutdiv,
  output logic                   o_hfxoscen
);

  // Clock generator slave bus
  logic                 hclk_cmd_valid;
  logic                 hclk_cmd_ready;
  logic [REG_OFS_W-1:0] hclk_cmd_addr;
  logic                 hclk_cmd_read;
  data_t                hclk_cmd_wdata;
  logic                 hclk_rsp_valid;
  logic                 hclk_rsp_ready;
  data_t                hclk_rsp_rdata;

  // GPIO slave bus
  logic                 gpio_cmd_valid;
  logic                 gpio_cmd_ready;
  logic [REG_OFS_W-1:0] gpio_cmd_addr;
  logic                 gpio_cmd_read;
  data_t                gpio_cmd_wdata;
  logic                 gpio_rsp_valid;
  logic                 gpio_rsp_ready;
  data_t                gpio_rsp_rdata;

  ppi_fabric u_fabric (
    .clk              (clk),
    .rst_n            (rst_n),
    .i_cmd_valid      (i_cmd_valid),
    .o_cmd_ready      (o_cmd_ready),
    .i_cmd_addr       (i_cmd_addr),
    .i_cmd_read       (i_cmd_read),
    .i_cmd_wdata      (i_cmd_wdata),
    .o_rsp_valid      (o_rsp_valid),
    .i_rsp_ready      (i_rsp_ready),
    .o_rsp_err        (o_rsp_err),
    .o_rsp_rdata      (o_rsp_rdata),
    .o_hclk_cmd_valid (hclk_cmd_valid),
    .i_hclk_cmd_ready (hclk_cmd_ready),
    .o_hclk_cmd_addr  (hclk_cmd_addr),
    .o_hclk_cmd_read  (hclk_cmd_read),
    .o_hclk_cmd_wdata (hclk_cmd_wdata),
    .i_hclk_rsp_valid (hclk_rsp_valid),
    .o_hclk_rsp_ready (hclk_rsp_ready),
    .i_hclk_rsp_rdata (hclk_rsp_rdata),
    .o_gpio_cmd_valid (gpio_cmd_valid),
    .i_gpio_cmd_ready (gpio_cmd_ready),
    .o_gpio_cmd_addr  (gpio_cmd_addr),
    .o_gpio_cmd_read  (gpio_cmd_read),
    .o_gpio_cmd_wdata (gpio_cmd_wdata),
    .i_gpio_rsp_valid (gpio_rsp_valid),
    .o_gpio_rsp_ready (gpio_rsp_ready),
    .i_gpio_rsp_rdata (gpio_rsp_rdata)
  );

  hclkgen_regs u_hclkgen (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_cmd_valid    (hclk_cmd_valid),
    .o_cmd_ready    (hclk_cmd_ready),
    .i_cmd_addr     (hclk_cmd_addr),
    .i_cmd_read     (hclk_cmd_read),
    .i_cmd_wdata    (hclk_cmd_wdata),
    .o_rsp_valid    (hclk_rsp_valid),
    .i_rsp_ready    (hclk_rsp_ready),
    .o_rsp_rdata    (hclk_rsp_rdata),
    .o_pllbypass    (o_pllbypass),
    .o_pll_reset    (o_pll_reset),
    .o_pll_asleep   (o_pll_asleep),
    .o_pll_od       (o_pll_od),
    .o_pll_m        (o_pll_m),
    .o_pll_n        (o_pll_n),
    .o_plloutdivby1 (o_plloutdivby1),
    .o_plloutdiv    (o_plloutdiv),
    .o_hfxoscen     (o_hfxoscen)
  );

  gpio_regs u_gpio (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_cmd_valid (gpio_cmd_valid),
    .o_cmd_ready (gpio_cmd_ready),
    .i_cmd_addr  (gpio_cmd_addr),
    .i_cmd_read  (gpio_cmd_read),
    .i_cmd_wdata (gpio_cmd_wdata),
    .o_rsp_valid (gpio_rsp_valid),
    .i_rsp_ready (gpio_rsp_ready),
    .o_rsp_rdata (gpio_rsp_rdata),
    .i_pad_ival  (i_gpio_ival),
    .o_pad_oval  (o_gpio_oval),
    .o_pad_oe    (o_gpio_oe),
    .o_pad_ie    (o_gpio_ie),
    .o_pad_pue   (o_gpio_pue),
    .o_pad_ds    (o_gpio_ds),
    .o_gpio_irq  (o_gpio_irq)
  );

endmodule

// ==== gpio_regs.sv ====
module gpio_regs
  import ppi_bus_pkg::*;
  import ppi_regs_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 i_cmd_valid,
  output logic                 o_cmd_ready,
  input  logic [REG_OFS_W-1:0] i_cmd_addr,
  input  logic                 i_cmd_read,
  input  data_t                i_cmd_wdata,
  output logic                 o_rsp_valid,
  input  logic                 i_rsp_ready,
  output data_t                o_rsp_rdata,
  // Pads
  input  logic [GPIO_W-1:0]    i_pad_ival,
  output logic [GPIO_W-1:0]    o_pad_oval,
  output logic [GPIO_W-1:0]    o_pad_oe,
  output logic [GPIO_W-1:0]    o_pad_ie,
  output logic [GPIO_W-1:0]    o_pad_pue,
  output logic [GPIO_W-1:0]    o_pad_ds,
  // One line per pin
  output logic [GPIO_W-1:0]    o_gpio_irq
);

  logic              cmd_fire;
  logic              cmd_write;
  logic [GPIO_W-1:0] sync1_q;
  logic [GPIO_W-1:0] sync2_q;
  logic [GPIO_W-1:0] value_q;
  logic [GPIO_W-1:0] value_dly_q;
  logic [GPIO_W-1:0] rise_ie_q;
  logic [GPIO_W-1:0] rise_ip_q;
  logic [GPIO_W-1:0] rise_clr;
  data_t             rd_data;

  assign o_cmd_ready = 1'b1;
  assign cmd_fire    = i_cmd_valid & o_cmd_ready;
  assign cmd_write   = cmd_fire & ~i_cmd_read;

  // Pad controls straight from the registers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_pad_ie   <= '0;
      o_pad_oe   <= '0;
      o_pad_oval <= '0;
      o_pad_pue  <= '0;
      o_pad_ds   <= '0;
      rise_ie_q  <= '0;
    end else if (cmd_write) begin
      case (i_cmd_addr)
        GPIO_INPUT_EN_OFS:  o_pad_ie   <= i_cmd_wdata[GPIO_W-1:0];
        GPIO_OUTPUT_EN_OFS: o_pad_oe   <= i_cmd_wdata[GPIO_W-1:0];
        GPIO_PORT_OFS:      o_pad_oval <= i_cmd_wdata[GPIO_W-1:0];
        GPIO_PUE_OFS:       o_pad_pue  <= i_cmd_wdata[GPIO_W-1:0];
        GPIO_DS_OFS:        o_pad_ds   <= i_cmd_wdata[GPIO_W-1:0];
        GPIO_RISE_IE_OFS:   rise_ie_q  <= i_cmd_wdata[GPIO_W-1:0];
        default: ;
      endcase
    end
  end

  // Two-flop synchronizer, then masked value and its previous copy
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync1_q     <= '0;
      sync2_q     <= '0;
      value_q     <= '0;
      value_dly_q <= '0;
    end else begin
      sync1_q     <= i_pad_ival;
      sync2_q     <= sync1_q;
      value_q     <= sync2_q & o_pad_ie;
      value_dly_q <= value_q;
    end
  end

  // Write one to clear
  assign rise_clr = (cmd_write && i_cmd_addr == GPIO_RISE_IP_OFS) ?
                    i_cmd_wdata[GPIO_W-1:0] : '0;

  // A new rising edge wins over a clear in the same cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rise_ip_q <= '0;
    end else begin
      rise_ip_q <= (rise_ip_q & ~rise_clr) | (value_q & ~value_dly_q);
    end
  end

  assign o_gpio_irq = rise_ip_q & rise_ie_q;

  always_comb begin
    case (i_cmd_addr)
      GPIO_VALUE_OFS:     rd_data = data_t'(value_q);
      GPIO_INPUT_EN_OFS:  rd_data = data_t'(o_pad_ie);
      GPIO_OUTPUT_EN_OFS: rd_data = data_t'(o_pad_oe);
      GPIO_PORT_OFS:      rd_data = data_t'(o_pad_oval);
      GPIO_PUE_OFS:       rd_data = data_t'(o_pad_pue);
      GPIO_DS_OFS:        rd_data = data_t'(o_pad_ds);
      GPIO_RISE_IE_OFS:   rd_data = data_t'(rise_ie_q);
      GPIO_RISE_IP_OFS:   rd_data = data_t'(rise_ip_q);
      default:            rd_data = '0;
    endcase
  end

  // Response one cycle after the command
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_rsp_valid <= 1'b0;
    end else if (cmd_fire) begin
      o_rsp_valid <= 1'b1;
    end else if (i_rsp_ready) begin
      o_rsp_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_fire) begin
      o_rsp_rdata <= i_cmd_read ? rd_data : '0;
    end
  end

  // A pending bit only sets on a pin whose input was enabled
  a_rise_needs_ie: assert property (@(posedge clk) disable iff (!rst_n)
    (rise_ip_q & ~$past(rise_ip_q) & ~$past(o_pad_ie, 2)) == '0);

endmodule

// ==== hclkgen_regs.sv ====
module hclkgen_regs
  import ppi_bus_pkg::*;
  import ppi_regs_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   i_cmd_valid,
  output logic                   o_cmd_ready,
  input  logic [REG_OFS_W-1:0]   i_cmd_addr,
  input  logic                   i_cmd_read,
  input  data_t                  i_cmd_wdata,
  output logic                   o_rsp_valid,
  input  logic                   i_rsp_ready,
  output data_t                  o_rsp_rdata,
  // PLL controls
  output logic                   o_pllbypass,
  output logic                   o_pll_reset,
  output logic                   o_pll_asleep,
  output logic [PLL_OD_W-1:0]    o_pll_od,
  output logic [PLL_M_W-1:0]     o_pll_m,
  output logic [PLL_N_W-1:0]     o_pll_n,
  // PLL output divider
  output logic                   o_plloutdivby1,
  output logic [PLLOUTDIV_W-1:0] o_plloutdiv,
  // Crystal oscillator enable
  output logic                   o_hfxoscen
);

  logic  cmd_fire;
  logic  cmd_write;
  data_t rd_data;

  // Single-cycle slave, fabric keeps one access open
  assign o_cmd_ready = 1'b1;
  assign cmd_fire    = i_cmd_valid & o_cmd_ready;
  assign cmd_write   = cmd_fire & ~i_cmd_read;

  // Control registers drive the outputs directly
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_pll_n        <= PLLCFG_RST[PLL_N_W-1:0];
      o_pll_m        <= PLLCFG_RST[PLL_M_LSB +: PLL_M_W];
      o_pll_od       <= PLLCFG_RST[PLL_OD_LSB +: PLL_OD_W];
      o_pllbypass    <= PLLCFG_RST[PLL_BYPASS_BIT];
      o_pll_reset    <= PLLCFG_RST[PLL_RESET_BIT];
      o_pll_asleep   <= PLLCFG_RST[PLL_ASLEEP_BIT];
      o_plloutdiv    <= PLLDIV_RST[PLLOUTDIV_W-1:0];
      o_plloutdivby1 <= PLLDIV_RST[PLLDIV_BY1_BIT];
      o_hfxoscen     <= HFXOSC_RST[HFXOSC_EN_BIT];
    end else if (cmd_write) begin
      case (i_cmd_addr)
        HCLK_PLLCFG_OFS: begin
          o_pll_n      <= i_cmd_wdata[PLL_N_W-1:0];
          o_pll_m      <= i_cmd_wdata[PLL_M_LSB +: PLL_M_W];
          o_pll_od     <= i_cmd_wdata[PLL_OD_LSB +: PLL_OD_W];
          o_pllbypass  <= i_cmd_wdata[PLL_BYPASS_BIT];
          o_pll_reset  <= i_cmd_wdata[PLL_RESET_BIT];
          o_pll_asleep <= i_cmd_wdata[PLL_ASLEEP_BIT];
        end
        HCLK_PLLDIV_OFS: begin
          o_plloutdiv    <= i_cmd_wdata[PLLOUTDIV_W-1:0];
          o_plloutdivby1 <= i_cmd_wdata[PLLDIV_BY1_BIT];
        end
        HCLK_HFXOSC_OFS: o_hfxoscen <= i_cmd_wdata[HFXOSC_EN_BIT];
        default: ;
      endcase
    end
  end

  // Readback in the packed layout, unused bits zero
  always_comb begin
    rd_data = '0;
    case (i_cmd_addr)
      HCLK_PLLCFG_OFS: begin
        rd_data[PLL_N_W-1:0]            = o_pll_n;
        rd_data[PLL_M_LSB +: PLL_M_W]   = o_pll_m;
        rd_data[PLL_OD_LSB +: PLL_OD_W] = o_pll_od;
        rd_data[PLL_BYPASS_BIT]         = o_pllbypass;
        rd_data[PLL_RESET_BIT]          = o_pll_reset;
        rd_data[PLL_ASLEEP_BIT]         = o_pll_asleep;
      end
      HCLK_PLLDIV_OFS: begin
        rd_data[PLLOUTDIV_W-1:0] = o_plloutdiv;
        rd_data[PLLDIV_BY1_BIT]  = o_plloutdivby1;
      end
      HCLK_HFXOSC_OFS: rd_data[HFXOSC_EN_BIT] = o_hfxoscen;
      default: ;
    endcase
  end

  // Response one cycle after the command
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_rsp_valid <= 1'b0;
    end else if (cmd_fire) begin
      o_rsp_valid <= 1'b1;
    end else if (i_rsp_ready) begin
      o_rsp_valid <= 1'b0;
    end
  end

  // Value seen before the write lands
  always_ff @(posedge clk) begin
    if (cmd_fire) begin
      o_rsp_rdata <= i_cmd_read ? rd_data : '0;
    end
  end

  // Held response until the fabric takes it
  a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    o_rsp_valid && !i_rsp_ready |=> o_rsp_valid && $stable(o_rsp_rdata));

endmodule

// ==== ppi_fabric.sv ====
module ppi_fabric
  import ppi_bus_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  // Upstream port
  input  logic                 i_cmd_valid,
  output logic                 o_cmd_ready,
  input  addr_t                i_cmd_addr,
  input  logic                 i_cmd_read,
  input  data_t                i_cmd_wdata,
  output logic                 o_rsp_valid,
  input  logic                 i_rsp_ready,
  output logic                 o_rsp_err,
  output data_t                o_rsp_rdata,
  // Clock generator slave
  output logic                 o_hclk_cmd_valid,
  input  logic                 i_hclk_cmd_ready,
  output logic [REG_OFS_W-1:0] o_hclk_cmd_addr,
  output logic                 o_hclk_cmd_read,
  output data_t                o_hclk_cmd_wdata,
  input  logic                 i_hclk_rsp_valid,
  output logic                 o_hclk_rsp_ready,
  input  data_t                i_hclk_rsp_rdata,
  // GPIO slave
  output logic                 o_gpio_cmd_valid,
  input  logic                 i_gpio_cmd_ready,
  output logic [REG_OFS_W-1:0] o_gpio_cmd_addr,
  output logic                 o_gpio_cmd_read,
  output data_t                o_gpio_cmd_wdata,
  input  logic                 i_gpio_rsp_valid,
  output logic                 o_gpio_rsp_ready,
  input  data_t                i_gpio_rsp_rdata
);

  ppi_target_e cmd_tgt;
  ppi_target_e tgt_q;
  logic        busy_q;
  logic        err_valid_q;
  logic        tgt_ready;
  logic        cmd_fire;
  logic        rsp_fire;

  // Compare the page bits of each kept region against its base
  always_comb begin
    if (i_cmd_addr[ADDR_W-1:HCLKGEN_REGION_LSB] ==
        HCLKGEN_BASE[ADDR_W-1:HCLKGEN_REGION_LSB]) begin
      cmd_tgt = TGT_HCLKGEN;
    end else if (i_cmd_addr[ADDR_W-1:GPIO_REGION_LSB] ==
                 GPIO_BASE[ADDR_W-1:GPIO_REGION_LSB]) begin
      cmd_tgt = TGT_GPIO;
    end else begin
      cmd_tgt = TGT_NONE;
    end
  end

  // Error responder never stalls a command
  always_comb begin
    case (cmd_tgt)
      TGT_HCLKGEN: tgt_ready = i_hclk_cmd_ready;
      TGT_GPIO:    tgt_ready = i_gpio_cmd_ready;
      default:     tgt_ready = 1'b1;
    endcase
  end

  // Closed from command transfer to response transfer
  assign o_cmd_ready = ~busy_q & tgt_ready;
  assign cmd_fire    = i_cmd_valid & o_cmd_ready;
  assign rsp_fire    = o_rsp_valid & i_rsp_ready;

  // Commands go straight through to the decoded slave
  assign o_hclk_cmd_valid = i_cmd_valid & ~busy_q & (cmd_tgt == TGT_HCLKGEN);
  assign o_hclk_cmd_addr  = i_cmd_addr[REG_OFS_W-1:0];
  assign o_hclk_cmd_read  = i_cmd_read;
  assign o_hclk_cmd_wdata = i_cmd_wdata;

  assign o_gpio_cmd_valid = i_cmd_valid & ~busy_q & (cmd_tgt == TGT_GPIO);
  assign o_gpio_cmd_addr  = i_cmd_addr[REG_OFS_W-1:0];
  assign o_gpio_cmd_read  = i_cmd_read;
  assign o_gpio_cmd_wdata = i_cmd_wdata;

  // Single outstanding access and its target
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q      <= 1'b0;
      tgt_q       <= TGT_NONE;
      err_valid_q <= 1'b0;
    end else begin
      if (cmd_fire) begin
        busy_q <= 1'b1;
        tgt_q  <= cmd_tgt;
      end else if (rsp_fire) begin
        busy_q <= 1'b0;
      end
      // Unmapped access answers one cycle later
      if (cmd_fire && cmd_tgt == TGT_NONE) begin
        err_valid_q <= 1'b1;
      end else if (rsp_fire) begin
        err_valid_q <= 1'b0;
      end
    end
  end

  // Only the owning slave sees rsp_ready
  assign o_hclk_rsp_ready = i_rsp_ready & busy_q & (tgt_q == TGT_HCLKGEN);
  assign o_gpio_rsp_ready = i_rsp_ready & busy_q & (tgt_q == TGT_GPIO);

  // Response return
  always_comb begin
    o_rsp_err = 1'b0;
    case (tgt_q)
      TGT_HCLKGEN: begin
        o_rsp_valid = busy_q & i_hclk_rsp_valid;
        o_rsp_rdata = i_hclk_rsp_rdata;
      end
      TGT_GPIO: begin
        o_rsp_valid = busy_q & i_gpio_rsp_valid;
        o_rsp_rdata = i_gpio_rsp_rdata;
      end
      default: begin
        // Error with zero data
        o_rsp_valid = err_valid_q;
        o_rsp_err   = busy_q;
        o_rsp_rdata = '0;
      end
    endcase
  end

  // Slaves see no new command while a slave response is still pending
  a_one_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
    (i_hclk_rsp_valid || i_gpio_rsp_valid) |-> !(o_hclk_cmd_valid || o_gpio_cmd_valid));

  // Stalled response keeps valid, error and data
  a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    o_rsp_valid && !i_rsp_ready |=>
      o_rsp_valid && $stable(o_rsp_err) && $stable(o_rsp_rdata));

endmodule

// ==== ppi_regs_pkg.sv ====
package ppi_regs_pkg;

  // Pin count of the GPIO bank
  localparam int GPIO_W = 32;

  // Clock generator offsets
  localparam HCLK_PLLCFG_OFS    = 12'h000;
  localparam HCLK_PLLDIV_OFS    = 12'h004;
  localparam HCLK_HFXOSC_OFS    = 12'h008;

  // GPIO offsets
  localparam GPIO_VALUE_OFS     = 12'h000;
  localparam GPIO_INPUT_EN_OFS  = 12'h004;
  localparam GPIO_OUTPUT_EN_OFS = 12'h008;
  localparam GPIO_PORT_OFS      = 12'h00C;
  localparam GPIO_PUE_OFS       = 12'h010;
  localparam GPIO_DS_OFS        = 12'h014;
  localparam GPIO_RISE_IE_OFS   = 12'h018;
  localparam GPIO_RISE_IP_OFS   = 12'h01C;

  // PLLCFG fields, packed up from bit 0
  localparam int PLL_N_W        = 5;
  localparam int PLL_M_W        = 8;
  localparam int PLL_OD_W       = 2;
  localparam int PLL_M_LSB      = PLL_N_W;
  localparam int PLL_OD_LSB     = PLL_M_LSB + PLL_M_W;
  localparam int PLL_BYPASS_BIT = PLL_OD_LSB + PLL_OD_W;
  localparam int PLL_RESET_BIT  = PLL_BYPASS_BIT + 1;
  localparam int PLL_ASLEEP_BIT = PLL_RESET_BIT + 1;

  // PLLDIV fields
  localparam int PLLOUTDIV_W    = 6;
  localparam int PLLDIV_BY1_BIT = 8;

  // HFXOSC enable
  localparam int HFXOSC_EN_BIT  = 0;

  // Bypass 1, M 0x32, N 1, rest clear
  localparam PLLCFG_RST = 32'h0000_8641;
  // Divide by one
  localparam PLLDIV_RST = 32'h0000_0100;
  // Crystal oscillator running
  localparam HFXOSC_RST = 32'h0000_0001;

endpackage

// ==== ppi_bus_pkg.sv ====
package ppi_bus_pkg;

  // Bus word and address widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // Low address bits handed to a register block
  localparam int REG_OFS_W = 12;

  // Private peripheral region spans 0x1000_0000 to 0x1FFF_FFFF
  // Clock generator, one 4 KiB page at 0x1000_8000
  localparam addr_t HCLKGEN_BASE       = 32'h1000_8000;
  localparam int    HCLKGEN_REGION_LSB = 12;

  // GPIO, one 4 KiB page at 0x1001_2000
  localparam addr_t GPIO_BASE          = 32'h1001_2000;
  localparam int    GPIO_REGION_LSB    = 12;

  // Target of one access
  // AON, OTP, UART1, QSPI1/2, PWM1/2, SysPer and the example slots all fall to TGT_NONE
  typedef enum logic [1:0] {
    TGT_HCLKGEN,
    TGT_GPIO,
    TGT_NONE
  } ppi_target_e;

endpackage
